/* design/placer_pkg.sv */
package placer_pkg;

  ////////////////////////////////////////
  // Widths that carry a meaning
  typedef logic [5:0]  pix_t;        // 6-bit pixel colour
  typedef logic [11:0] vaddr_t;      // Frame-buffer address, up to 4096 pixels
  typedef logic [6:0]  xcoord_t;     // Screen column
  typedef logic [5:0]  ycoord_t;     // Screen row
  typedef logic [8:0]  romaddr_t;    // Local address into sprite or font ROM
  typedef logic [1:0]  sprite_idx_t; // One of four sprites
  typedef logic [2:0]  glyph_idx_t;  // One of eight glyphs

  ////////////////////////////////////////
  // Pixel constants
  localparam pix_t BACKGRND = 6'h3F; // Clear and remove colour
  localparam pix_t TRANSP   = 6'h24; // Never reaches the frame buffer

  // Font format, fixed by the glyph ROM contents
  localparam int GLYPH_W = 5;
  localparam int GLYPH_H = 7;

  ////////////////////////////////////////
  // Bundles

  // One frame-buffer write
  typedef struct packed {
    vaddr_t addr;
    pix_t   data;
    logic   we;
  } vid_wr_t;

  // Command as latched on acceptance
  typedef struct packed {
    logic [2:0] indx;   // Sprite or glyph number
    xcoord_t    x;
    ycoord_t    y;
  } place_cmd_t;

  // Control FSM
  typedef enum logic [2:0] {
    CLEAR,      // Fill screen with background after reset
    IDLE,       // Only state with busy low
    HDR_ADR,    // ROM address cycle
    HDR_W,      // Width word on ROM output
    HDR_H,      // Height word on ROM output
    COPY_IMG,   // One sprite pixel per cycle
    COPY_CHR    // One glyph pixel per cycle
  } ctrl_state_t;

endpackage

/* design/sprite_rom.sv */
module sprite_rom (
  input  logic                    clk,
  input  placer_pkg::sprite_idx_t sel,
  input  placer_pkg::romaddr_t    addr,
  output placer_pkg::pix_t        data
);
  import placer_pkg::*;

  localparam int DEPTH = 16;                     // Words per sprite, header included
  localparam int AW    = $clog2(DEPTH);

  ////////////////////////////////////////
  // Sprite tables
  // Word 0 is width, word 1 height, then pixels row by row
  localparam pix_t SPRITES [4][DEPTH] = '{
    '{                                           // 0, solid 4 by 3 block
      6'h04, 6'h03,
      6'h01, 6'h02, 6'h03, 6'h04,
      6'h05, 6'h06, 6'h07, 6'h08,
      6'h09, 6'h0A, 6'h0B, 6'h0C,
      TRANSP, TRANSP
    },
    '{                                           // 1, 3 by 3 cross
      6'h03, 6'h03,
      TRANSP, 6'h10, TRANSP,
      6'h11, 6'h12, 6'h13,
      TRANSP, 6'h14, TRANSP,
      TRANSP, TRANSP, TRANSP, TRANSP, TRANSP
    },
    '{                                           // 2, wide 7 by 2 bar
      6'h07, 6'h02,
      6'h15, 6'h16, 6'h17, 6'h18, 6'h19, 6'h1A, 6'h1B,
      6'h1C, 6'h1D, 6'h1E, 6'h1F, 6'h20, 6'h21, 6'h22
    },
    '{                                           // 3, tall 2 by 5 with holes
      6'h02, 6'h05,
      6'h30, 6'h31,
      6'h32, TRANSP,
      6'h34, 6'h35,
      TRANSP, 6'h37,
      6'h38, 6'h39,
      TRANSP, TRANSP, TRANSP, TRANSP
    }
  };

  ////////////////////////////////////////
  // Registered read
  always_ff @(posedge clk) begin
    if (addr < romaddr_t'(DEPTH))
      data <= SPRITES[sel][addr[AW-1:0]];
    else
      data <= TRANSP;                            // Past the table reads as see-through
  end

endmodule

/* design/glyph_rom.sv */
module glyph_rom (
  input  logic                   clk,
  input  placer_pkg::glyph_idx_t sel,
  input  placer_pkg::romaddr_t   addr,     // Row-major pixel position
  output placer_pkg::pix_t       data
);
  import placer_pkg::*;

  localparam int   NPIX = GLYPH_W * GLYPH_H;
  localparam pix_t INK  = 6'h2A;           // Foreground colour of every glyph

  ////////////////////////////////////////
  // Digits 0 to 7, one row per group of five bits
  // MSB is top left
  localparam logic [NPIX-1:0] FONT [8] = '{
    35'b01110_10001_10011_10101_11001_10001_01110,   // 0
    35'b00100_01100_00100_00100_00100_00100_01110,   // 1
    35'b01110_10001_00001_00010_00100_01000_11111,   // 2
    35'b11111_00010_00100_00010_00001_10001_01110,   // 3
    35'b00010_00110_01010_10010_11111_00010_00010,   // 4
    35'b11111_10000_11110_00001_00001_10001_01110,   // 5
    35'b00110_01000_10000_11110_10001_10001_01110,   // 6
    35'b11111_00001_00010_00100_01000_01000_01000    // 7
  };

  logic [5:0] bit_pos;   // Bit within the packed glyph
  logic       lit;       // Pixel is ink, not background

  assign bit_pos = 6'(NPIX - 1) - addr[5:0];
  assign lit     = (addr < romaddr_t'(NPIX)) && FONT[sel][bit_pos];

  // Off pixels come out transparent so the old screen shows through
  always_ff @(posedge clk) begin
    data <= lit ? INK : TRANSP;
  end

endmodule

/* design/vid_addr_gen.sv */
module vid_addr_gen #(
  parameter int SCREEN_W = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load_pos,    // Take start position
  input  logic                load_w,      // Take width header word
  input  logic                load_h,      // Take height header word
  input  logic                step,        // Advance one write slot
  input  logic                clear,       // Plain linear walk, no rows
  input  placer_pkg::xcoord_t x,
  input  placer_pkg::ycoord_t y,
  input  placer_pkg::pix_t    dim,         // Header word from the sprite ROM
  input  logic                glyph,       // Fixed font size instead of header
  output placer_pkg::vaddr_t  addr,
  output logic                row_end,
  output logic                copy_done
);
  import placer_pkg::*;

  localparam vaddr_t LINE = vaddr_t'(SCREEN_W);

  pix_t wid;      // Sprite width
  pix_t hgt;      // Sprite height
  pix_t cur_w;
  pix_t cur_h;
  pix_t col;      // Column of current slot
  pix_t row;      // Row of current slot

  ////////////////////////////////////////
  // Image size
  always_ff @(posedge clk) begin
    if (load_w)
      wid <= dim;
    if (load_h)
      hgt <= dim;
  end

  assign cur_w = glyph ? pix_t'(GLYPH_W) : wid;
  assign cur_h = glyph ? pix_t'(GLYPH_H) : hgt;

  // Last column of a row, and last slot of the copy
  assign row_end   = !clear && (col == cur_w - 1'b1);
  assign copy_done = row_end && (row == cur_h - 1'b1);

  ////////////////////////////////////////
  // Write address walk
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      addr <= '0;                          // Clear starts at the top left
      col  <= '0;
      row  <= '0;
    end else if (load_pos) begin
      addr <= vaddr_t'(y) * LINE + vaddr_t'(x);
      col  <= '0;
      row  <= '0;
    end else if (step) begin
      if (clear) begin
        addr <= addr + 1'b1;
      end else if (row_end) begin
        // Skip the rest of the screen line to the next image row
        addr <= addr + (LINE - vaddr_t'(cur_w)) + vaddr_t'(1);
        col  <= '0;
        row  <= row + 1'b1;
      end else begin
        addr <= addr + 1'b1;
        col  <= col + 1'b1;
      end
    end
  end

endmodule

/* design/placer_ctrl.sv */
module placer_ctrl #(
  parameter int SCREEN_W = 64,
  parameter int SCREEN_H = 48
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    add_img,     // Pulse, place sprite
  input  logic                    rem_img,     // Pulse, erase sprite footprint
  input  logic                    add_fnt,     // Pulse, place glyph
  input  placer_pkg::sprite_idx_t image_indx,
  input  placer_pkg::glyph_idx_t  fnt_indx,
  input  placer_pkg::xcoord_t     xloc,
  input  placer_pkg::ycoord_t     yloc,
  input  placer_pkg::pix_t        sprite_data,
  input  placer_pkg::pix_t        glyph_data,
  input  placer_pkg::vaddr_t      addr,        // Current write address
  input  logic                    row_end,
  input  logic                    copy_done,
  output placer_pkg::sprite_idx_t sprite_sel,
  output placer_pkg::glyph_idx_t  glyph_sel,
  output placer_pkg::romaddr_t    rom_addr,
  output placer_pkg::place_cmd_t  cmd,         // Latched command
  output logic                    load_pos,
  output logic                    load_w,
  output logic                    load_h,
  output logic                    step,
  output logic                    clear,       // Linear address walk
  output logic                    glyph,       // Current command is a character
  output placer_pkg::vid_wr_t     wr,
  output logic                    busy
);
  import placer_pkg::*;

  localparam vaddr_t LAST_ADDR = vaddr_t'(SCREEN_W * SCREEN_H - 1);

  ctrl_state_t state;
  ctrl_state_t nxt_state;
  logic        clr_go;    // Low in the first cycle out of reset only
  logic        rem;       // Remove in progress
  logic        img_cmd;
  logic        accept;
  logic        rom_inc;
  logic [2:0]  gcol;      // Glyph column of the current slot
  logic [2:0]  grow;      // Glyph row of the current slot
  logic        chr_last;

  assign img_cmd = add_img | rem_img;                  // Images win over characters
  assign accept  = (state == IDLE) & (img_cmd | add_fnt);

  ////////////////////////////////////////
  // State and clear start flag
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state  <= CLEAR;
      clr_go <= 1'b0;
    end else begin
      state  <= nxt_state;
      clr_go <= 1'b1;
    end
  end

  // Command fields, only read after acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.indx <= img_cmd ? {1'b0, image_indx} : fnt_indx;
      cmd.x    <= xloc;
      cmd.y    <= yloc;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rem   <= 1'b0;
      glyph <= 1'b0;
    end else if (accept) begin
      rem   <= rem_img;
      glyph <= ~img_cmd;
    end
  end

  // ROM fetch address, one ahead of the write slot
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rom_addr <= '0;
    end else if (accept) begin
      rom_addr <= '0;                                  // Header words sit at 0 and 1
    end else if (rom_inc) begin
      rom_addr <= rom_addr + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Glyph column and row count
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      gcol <= '0;
      grow <= '0;
    end else if (accept) begin
      gcol <= '0;
      grow <= '0;
    end else if (state == COPY_CHR) begin
      if (row_end) begin                               // Wrap with the address generator
        gcol <= '0;
        grow <= grow + 1'b1;
      end else begin
        gcol <= gcol + 1'b1;
      end
    end
  end

  assign chr_last = (gcol == 3'(GLYPH_W - 1)) && (grow == 3'(GLYPH_H - 1));

  ////////////////////////////////////////
  // Next state and write formation
  always_comb begin
    nxt_state = state;
    busy      = 1'b1;
    load_pos  = 1'b0;
    load_w    = 1'b0;
    load_h    = 1'b0;
    step      = 1'b0;
    rom_inc   = 1'b0;
    wr.addr   = addr;
    wr.data   = BACKGRND;
    wr.we     = 1'b0;
    case (state)
      CLEAR: begin
        wr.we = clr_go;                                // One dead cycle after reset
        step  = clr_go;
        if (clr_go && (addr == LAST_ADDR))
          nxt_state = IDLE;
      end
      IDLE: begin
        busy = 1'b0;
        if (img_cmd | add_fnt)
          nxt_state = HDR_ADR;
      end
      HDR_ADR: begin
        load_pos  = 1'b1;                              // Start address from latched x, y
        rom_inc   = 1'b1;
        nxt_state = glyph ? COPY_CHR : HDR_W;          // Glyphs carry no header
      end
      HDR_W: begin
        load_w    = 1'b1;
        rom_inc   = 1'b1;
        nxt_state = HDR_H;
      end
      HDR_H: begin
        load_h    = 1'b1;
        rom_inc   = 1'b1;
        nxt_state = COPY_IMG;
      end
      COPY_IMG: begin
        step    = 1'b1;
        rom_inc = 1'b1;
        wr.data = rem ? BACKGRND : sprite_data;
        wr.we   = (sprite_data != TRANSP);             // Remove keeps the sprite's mask
        if (copy_done)
          nxt_state = IDLE;
      end
      COPY_CHR: begin
        step    = 1'b1;
        rom_inc = 1'b1;
        wr.data = glyph_data;
        wr.we   = (glyph_data != TRANSP);
        if (chr_last)
          nxt_state = IDLE;
      end
      default: nxt_state = IDLE;
    endcase
  end

  assign clear      = (state == CLEAR);
  assign sprite_sel = cmd.indx[1:0];
  assign glyph_sel  = cmd.indx;

endmodule

/* design/bmp_placer.sv */
module bmp_placer #(
  parameter int SCREEN_W = 64,
  parameter int SCREEN_H = 48
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    add_img,
  input  logic                    rem_img,
  input  logic                    add_fnt,
  input  placer_pkg::sprite_idx_t image_indx,
  input  placer_pkg::glyph_idx_t  fnt_indx,
  input  placer_pkg::xcoord_t     xloc,
  input  placer_pkg::ycoord_t     yloc,
  output placer_pkg::vid_wr_t     wr,          // Frame-buffer write port
  output logic                    busy         // Commands dropped while high
);
  import placer_pkg::*;

  sprite_idx_t sprite_sel;
  glyph_idx_t  glyph_sel;
  romaddr_t    rom_addr;    // Shared by both ROMs
  pix_t        sprite_data;
  pix_t        glyph_data;
  place_cmd_t  cmd;
  vaddr_t      addr;
  logic        row_end;
  logic        copy_done;
  logic        load_pos;
  logic        load_w;
  logic        load_h;
  logic        step;
  logic        clear;
  logic        glyph;

  ////////////////////////////////////////
  // Control FSM
  placer_ctrl #(
    .SCREEN_W(SCREEN_W),
    .SCREEN_H(SCREEN_H)
  ) ctrl_i (
    .clk(clk),
    .rst_n(rst_n),
    .add_img(add_img),
    .rem_img(rem_img),
    .add_fnt(add_fnt),
    .image_indx(image_indx),
    .fnt_indx(fnt_indx),
    .xloc(xloc),
    .yloc(yloc),
    .sprite_data(sprite_data),
    .glyph_data(glyph_data),
    .addr(addr),
    .row_end(row_end),
    .copy_done(copy_done),
    .sprite_sel(sprite_sel),
    .glyph_sel(glyph_sel),
    .rom_addr(rom_addr),
    .cmd(cmd),
    .load_pos(load_pos),
    .load_w(load_w),
    .load_h(load_h),
    .step(step),
    .clear(clear),
    .glyph(glyph),
    .wr(wr),
    .busy(busy)
  );

  ////////////////////////////////////////
  // Image stores
  sprite_rom sprite_rom_i (
    .clk(clk),
    .sel(sprite_sel),
    .addr(rom_addr),
    .data(sprite_data)
  );

  glyph_rom glyph_rom_i (
    .clk(clk),
    .sel(glyph_sel),
    .addr(rom_addr),
    .data(glyph_data)
  );

  ////////////////////////////////////////
  // Write address datapath
  vid_addr_gen #(
    .SCREEN_W(SCREEN_W)
  ) addr_gen_i (
    .clk(clk),
    .rst_n(rst_n),
    .load_pos(load_pos),
    .load_w(load_w),
    .load_h(load_h),
    .step(step),
    .clear(clear),
    .x(cmd.x),              // Position from the latched command
    .y(cmd.y),
    .dim(sprite_data),      // Header words arrive on the sprite ROM output
    .glyph(glyph),
    .addr(addr),
    .row_end(row_end),
    .copy_done(copy_done)
  );

endmodule

/* testbench/bmp_placer_sva.sv */
module bmp_placer_sva #(
  parameter int SCREEN_W = 64,
  parameter int SCREEN_H = 48
) (
  input logic                clk,
  input logic                rst_n,
  input placer_pkg::vid_wr_t wr,
  input logic                busy
);
  import placer_pkg::*;

  localparam int NPIX = SCREEN_W * SCREEN_H;

  ////////////////////////////////////////
  // Writes only while busy
  a_we_busy: assert property (@(posedge clk) disable iff (!rst_n) wr.we |-> busy)
    else $error("write enable high while busy is low");

  // Address stays on screen
  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr.we |-> (int'(wr.addr) < NPIX))
    else $error("write address %0d off screen", wr.addr);

  a_no_transp: assert property (@(posedge clk) disable iff (!rst_n)
    wr.we |-> (wr.data != TRANSP))                   // Transparent never reaches the buffer
    else $error("transparent pixel written at %0d", wr.addr);

endmodule

bind bmp_placer bmp_placer_sva #(
  .SCREEN_W(SCREEN_W),
  .SCREEN_H(SCREEN_H)
) sva_i (
  .clk(clk),
  .rst_n(rst_n),
  .wr(wr),
  .busy(busy)
);

/* testbench/bmp_placer_tb.sv */
module bmp_placer_tb;
  import placer_pkg::*;

  localparam int SCREEN_W = 64;
  localparam int SCREEN_H = 48;
  localparam int NPIX     = SCREEN_W * SCREEN_H;
  localparam int MAXT     = 32;
  localparam int HOLE_ADR = 21 * SCREEN_W + 41;    // Hole of sprite 3 over sprite 0 pixel 6

  logic        clk;
  logic        rst_n;
  logic        add_img;
  logic        rem_img;
  logic        add_fnt;
  sprite_idx_t image_indx;
  glyph_idx_t  fnt_indx;
  xcoord_t     xloc;
  ycoord_t     yloc;
  vid_wr_t     wr;
  logic        busy;

  // Test table from the vector file
  logic [127:0] t_name [MAXT];
  logic [31:0]  t_cmd [MAXT];
  int           t_idx [MAXT];
  int           t_x [MAXT];
  int           t_y [MAXT];
  int           t_cnt [MAXT];
  int           t_first [MAXT];
  int           t_last [MAXT];
  int           t_sum [MAXT];
  int           ntests;

  // Sprite widths and heights
  int           spr_w [4] = '{4, 3, 7, 2};
  int           spr_h [4] = '{3, 3, 2, 5};

  pix_t         fb [NPIX];         // Frame-buffer model
  int           hits [NPIX];       // Writes per address during the clear
  logic         in_clear;
  int           clear_bad;
  int           cnt, sum, amin, amax, out_rect, total;
  int           rx, ry, rw, rh;    // Rectangle of the running command
  int           cur_q [$];         // Addresses written by the running command
  int           add_adr_q [$];     // Addresses placed by earlier adds
  int           add_idx_q [$];
  int           fails, passed, failed;
  logic         test_bad;
  int unsigned  rng_state = 87;
  int           cycles;
  int           limit = 200000;    // Tightened once the vectors are in

  bmp_placer #(
    .SCREEN_W(SCREEN_W),
    .SCREEN_H(SCREEN_H)
  ) bmp_placer_i (
    .clk(clk), .rst_n(rst_n),
    .add_img(add_img), .rem_img(rem_img), .add_fnt(add_fnt),
    .image_indx(image_indx), .fnt_indx(fnt_indx),
    .xloc(xloc), .yloc(yloc),
    .wr(wr), .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Write monitor sampled mid cycle
  always @(negedge clk) begin
    int col;
    int row;
    if (rst_n && wr.we) begin
      fb[wr.addr] = wr.data;
      if (in_clear) begin
        hits[wr.addr] = hits[wr.addr] + 1;
        if (wr.data != BACKGRND)
          clear_bad = clear_bad + 1;
      end else begin
        col = int'(wr.addr) % SCREEN_W - rx;
        row = int'(wr.addr) / SCREEN_W - ry;
        if (col < 0 || col >= rw || row < 0 || row >= rh)
          out_rect = out_rect + 1;
        cnt   = cnt + 1;
        total = total + 1;
        sum   = sum + int'(wr.data);
        if (int'(wr.addr) < amin)
          amin = int'(wr.addr);
        if (int'(wr.addr) > amax)
          amax = int'(wr.addr);
        cur_q.push_back(int'(wr.addr));
      end
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("timeout after %0d cycles, busy did not fall in time", cycles);
    $display("Simulation failed");
    $finish;
  end

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;
  endfunction

  task automatic check_value(input logic [127:0] tname, input string what,
                             input int expv, input int actv);
    assert (expv == actv)
    else begin
      $display("error %0s %0s expected %0d actual %0d", tname, what, expv, actv);
      fails    = fails + 1;
      test_bad = 1'b1;
    end
  endtask

  // Per-command write statistics back to empty
  task automatic reset_counts();
    cnt      = 0;
    sum      = 0;
    amin     = NPIX;
    amax     = -1;
    out_rect = 0;
    cur_q.delete();
    test_bad = 1'b0;
  endtask

  task automatic load_vectors(input int fd);
    logic [8*100-1:0] line;
    logic [127:0]     nm;
    logic [31:0]      cm;
    int               a, b, c, d, e, f, g, h;
    int               code;
    int               slots;
    ntests = 0;
    slots  = 0;
    while (!$feof(fd) && ntests < MAXT) begin
      line = '0;
      code = $fgets(line, fd);
      code = $sscanf(line, "%s %s %d %d %d %d %d %d %d", nm, cm, a, b, c, d, e, f, g);
      if (code == 9) begin                           // Comment and blank lines fall out here
        t_name[ntests]  = nm;
        t_cmd[ntests]   = cm;
        t_idx[ntests]   = a;
        t_x[ntests]     = b;
        t_y[ntests]     = c;
        t_cnt[ntests]   = d;
        t_first[ntests] = e;
        t_last[ntests]  = f;
        t_sum[ntests]   = g;
        h = (cm == "chr") ? GLYPH_W * GLYPH_H : spr_w[a % 4] * spr_h[a % 4];
        slots  = slots + h + 4 + 12;                 // Header, handshake and extra pulse
        ntests = ntests + 1;
      end
    end
    $fclose(fd);
    limit = NPIX + 20 + slots + 200;
  endtask

  task automatic wait_idle();
    do @(negedge clk); while (busy);
  endtask

  ////////////////////////////////////////
  // One command with an ignored pulse inside it
  task automatic run_test(input int t);
    int k;
    int i;
    int q_a [$];
    int q_i [$];
    reset_counts();
    rx = t_x[t];
    ry = t_y[t];
    rw = (t_cmd[t] == "chr") ? GLYPH_W : spr_w[t_idx[t] % 4];
    rh = (t_cmd[t] == "chr") ? GLYPH_H : spr_h[t_idx[t] % 4];
    @(posedge clk);
    #5;
    add_img    = (t_cmd[t] == "add");
    rem_img    = (t_cmd[t] == "rem");
    add_fnt    = (t_cmd[t] == "chr");
    image_indx = sprite_idx_t'(t_idx[t]);
    fnt_indx   = glyph_idx_t'(t_idx[t]);
    xloc       = xcoord_t'(t_x[t]);
    yloc       = ycoord_t'(t_y[t]);
    @(posedge clk);
    #5;
    add_img = 1'b0;
    rem_img = 1'b0;
    add_fnt = 1'b0;
    k = 1 + int'(lcg_next() % 6);
    repeat (k) @(posedge clk);
    #5;
    assert (busy)
    else begin
      $display("extra pulse in %0s could not be sent while busy", t_name[t]);
      fails    = fails + 1;
      test_bad = 1'b1;
    end
    add_fnt  = 1'b1;                                 // Must be dropped
    fnt_indx = 3'd7;
    @(posedge clk);
    #5;
    add_fnt = 1'b0;
    wait_idle();
    check_value(t_name[t], "count", t_cnt[t], cnt);
    check_value(t_name[t], "first", t_first[t], amin);
    check_value(t_name[t], "last", t_last[t], amax);
    check_value(t_name[t], "sum", t_sum[t], sum);
    assert (out_rect == 0)
    else begin
      $display("%0s wrote %0d pixels outside its rectangle", t_name[t], out_rect);
      fails    = fails + 1;
      test_bad = 1'b1;
    end
    if (t_name[t] == "s3_over")
      check_value(t_name[t], "hole", 6, int'(fb[HOLE_ADR]));
    if (t_cmd[t] == "add") begin
      foreach (cur_q[j]) begin
        add_adr_q.push_back(cur_q[j]);
        add_idx_q.push_back(t_idx[t]);
      end
    end else if (t_cmd[t] == "rem") begin
      // Every pixel the sprite placed is background again
      for (i = 0; i < add_adr_q.size(); i++) begin
        if (add_idx_q[i] == t_idx[t])
          check_value(t_name[t], "removed pixel", int'(BACKGRND), int'(fb[add_adr_q[i]]));
        else begin
          q_a.push_back(add_adr_q[i]);
          q_i.push_back(add_idx_q[i]);
        end
      end
      add_adr_q = q_a;
      add_idx_q = q_i;
    end
    if (test_bad) failed = failed + 1;
    else passed = passed + 1;
    $display("test %0s %0s", t_name[t], test_bad ? "failed" : "ok");
  endtask

  task automatic run_all();
    int a;
    int exp_total;
    in_clear = 1'b1;
    repeat (8) @(posedge clk);
    #5;
    rst_n = 1'b1;
    wait_idle();
    in_clear = 1'b0;
    test_bad = 1'b0;
    for (a = 0; a < NPIX; a++)
      check_value("clear", "hits", 1, hits[a]);
    check_value("clear", "non background writes", 0, clear_bad);
    if (test_bad) failed = failed + 1;
    else passed = passed + 1;
    $display("test clear %0s", test_bad ? "failed" : "ok");
    exp_total = 0;
    for (a = 0; a < ntests; a++) begin
      run_test(a);
      exp_total = exp_total + t_cnt[a];
    end
    check_value("all", "total writes", exp_total, total);
  endtask

  initial begin
    int fd;
    rst_n      = 1'b0;
    add_img    = 1'b0;
    rem_img    = 1'b0;
    add_fnt    = 1'b0;
    image_indx = '0;
    fnt_indx   = '0;
    xloc       = '0;
    yloc       = '0;
    in_clear   = 1'b0;
    clear_bad  = 0;
    total      = 0;
    reset_counts();
    rx     = 0;
    ry     = 0;
    rw     = SCREEN_W;
    rh     = SCREEN_H;
    fails  = 0;
    passed = 0;
    failed = 0;
    for (int a = 0; a < NPIX; a++) begin
      fb[a]   = '0;
      hits[a] = 0;
    end
    fd = $fopen("testbench/placer_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file");
      $display("Simulation failed");
      $finish;
    end else begin
      load_vectors(fd);
      run_all();
      $display("tests %0d passed %0d failed %0d errors %0d",
               passed + failed, passed, failed, fails);
      if (fails == 0)
        $display("Simulation completed successfully");
      else
        $display("Simulation failed");
      $finish;
    end
  end

endmodule

/* testbench/placer_vectors.txt */
# name cmd idx x y count first last sum
# cmd is add, rem or chr; addresses and sum are decimal
s0_base add 0 40 20 12 1320 1451 78
s3_over add 3 40 20 8 1320 1577 420
s1_add add 1 10 5 5 331 459 90
s2_add add 2 20 10 14 660 730 385
s0_add add 0 2 3 12 194 325 78
s1_rem rem 1 10 5 5 331 459 315
s3_rem rem 3 40 20 8 1320 1577 504
g0_add chr 0 50 2 19 179 565 798
g1_add chr 1 5 30 10 1927 2312 420
g7_add chr 7 58 40 11 2618 3003 462
g4_add chr 4 0 0 14 3 387 588
s2_rem rem 2 20 10 14 660 730 882

/* verilog.f */
design/placer_pkg.sv
design/sprite_rom.sv
design/glyph_rom.sv
design/vid_addr_gen.sv
design/placer_ctrl.sv
design/bmp_placer.sv
testbench/bmp_placer_sva.sv
testbench/bmp_placer_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the placer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module bmp_placer_tb -f verilog.f -o sim_bmp_placer
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_bmp_placer)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
